/* run.sh */
#!/usr/bin/env bash
# builds the icache tag testbench with Verilator and runs it, the exit status is the result
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert -f tb.f --top-module tb_icache_tag -Mdir obj_dir &&
	./obj_dir/Vtb_icache_tag ||
	{ echo "build or simulation ended with an error" >&2; exit 1; }

/* tb.f */
+incdir+verilog
verilog/icache_tag_pkg.sv
verilog/tag_ram_model.sv
verilog/icache_tag_ecc_ram.sv
verilog/tag_ecc_check.sv
verilog/tag_lookup.sv
verilog/tag_cfg_regs.sv
verilog/icache_tag_top.sv
verif/tb_icache_tag.sv

/* verif/icache_tag_testdata.txt */
# columns: test name, command, fields in hex. C addr data, F index tag lock, R addr expected data
# L index tag then expected bits hit lock corrected uncorrectable; L lines in a row go back to back
fill_a F 05 abcde 1
hit_a L 05 abcde 1100
fill_b F 06 12345 0
miss_tag L 05 abcdf 0100
pipe_a L 05 abcde 1100
pipe_b L 06 12345 1000
inj_data C 1 00000080
fill_c F 0a 0f0f0 0
inject_clear R 1 00000000
corr_data L 0a 0f0f0 1010
inj_check C 1 00000004
fill_d F 0b 55555 1
corr_check L 0b 55555 1110
inj_double C 1 00000180
fill_e F 0c 33333 1
double_err L 0c 33333 0101
ecc_off C 0 00000000
ctrl_off R 0 00000000
inj_raw C 1 00000080
fill_f F 0d 77777 0
raw_miss L 0d 77777 0000
inj_valid C 1 10000000
fill_g F 0e 24680 1
invalid_miss L 0e 24680 0100
corr_kept R 2 00000002
uncorr_kept R 3 00000001
clr_corr C 2 ffffffff
corr_cleared R 2 00000000

/* verif/tb_icache_tag.sv */
// testbench for the icache tag array, replays verif/icache_tag_testdata.txt against the top level
`timescale 1ns/10ps
`default_nettype none
`include "icache_tag_defines.svh"

module tb_icache_tag;

	import icache_tag_pkg::*;

	localparam int RSP_TIMEOUT = 10;

	typedef struct packed {
		logic [8*24-1:0] name;
		logic [3:0] flags; // hit, lock, corrected, uncorrectable
		logic [31:0] issued;
	} pending_t;

	logic clk;
	logic rst;
	lookup_req_t lookup_req;
	fill_req_t fill_req;
	cfg_req_t cfg_req;
	lookup_rsp_t lookup_rsp;
	logic [31:0] cfg_rdata;

	pending_t pending[$];
	logic [31:0] cycle;

	icache_tag_top u_dut (
		.clk(clk),
		.rst(rst),
		.lookup_req(lookup_req),
		.fill_req(fill_req),
		.lookup_rsp(lookup_rsp),
		.cfg_req(cfg_req),
		.cfg_rdata(cfg_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic stop_with_error(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "stopped at cycle %0d", cycle);
	endtask

	task automatic report_mismatch(input logic [8*24-1:0] name, input logic [31:0] exp,
		input logic [31:0] act);
		stop_with_error($sformatf("** Error %0s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic idle_inputs();
		lookup_req = '0;
		fill_req = '0;
		cfg_req = '0;
	endtask

	// moves to 1 ns after the next rising edge and checks any response seen there
	task automatic step_cycle();
		pending_t p;
		logic [3:0] got;
		@(posedge clk);
		#1;
		cycle = cycle + 1;
		if (lookup_rsp.vld) begin
			assert (pending.size() != 0)
				else stop_with_error("lookup response arrived with no lookup pending");
			p = pending.pop_front();
			got = {lookup_rsp.hit, lookup_rsp.lock, lookup_rsp.corrected, lookup_rsp.uncorrectable};
			assert (cycle - p.issued == 2)
				else report_mismatch(p.name, 2, cycle - p.issued);
			assert (got == p.flags)
				else report_mismatch(p.name, {28'b0, p.flags}, {28'b0, got});
		end
	endtask

	task automatic drain_lookups();
		int waited;
		waited = 0;
		if (pending.size() != 0) begin
			while (pending.size() != 0) begin
				assert (waited < RSP_TIMEOUT)
					else stop_with_error("timeout while waiting for a lookup response");
				step_cycle();
				waited++;
			end
			step_cycle(); // error counters move one edge after the response
		end
	endtask

	task automatic skip_line(input int fd);
		int ch;
		ch = $fgetc(fd);
		while (ch != 10 && ch != -1)
			ch = $fgetc(fd);
	endtask

	task automatic run_command(input int fd, input logic [8*24-1:0] name, input logic [7:0] cmd);
		int r;
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] f2;
		pending_t p;
		if (cmd == "L")
			r = $fscanf(fd, "%h %h %b", f0, f1, f2);
		else if (cmd == "F")
			r = $fscanf(fd, "%h %h %h", f0, f1, f2);
		else
			r = $fscanf(fd, "%h %h", f0, f1) + 1;
		assert (r == 3)
			else stop_with_error($sformatf("malformed data line for test %0s", name));
		if (cmd != "L")
			drain_lookups(); // lookups in a row stay back to back
		case (cmd)
			"L": begin
				lookup_req.vld = 1'b1;
				lookup_req.index = f0[`TAG_IDX_W-1:0];
				lookup_req.tag = f1[`TAG_ADDR_W-1:0];
				p.name = name;
				p.flags = f2[3:0];
				p.issued = cycle;
				pending.push_back(p);
			end
			"F": begin
				fill_req.vld = 1'b1;
				fill_req.index = f0[`TAG_IDX_W-1:0];
				fill_req.tag = f1[`TAG_ADDR_W-1:0];
				fill_req.lock = f2[0];
			end
			"C", "R": begin
				cfg_req.vld = 1'b1;
				cfg_req.we = (cmd == "C");
				cfg_req.addr = f0[`CFG_ADDR_W-1:0];
				cfg_req.wdata = (cmd == "C") ? f1 : 32'b0;
			end
			default: stop_with_error($sformatf("unknown command in data line for test %0s", name));
		endcase
		step_cycle();
		idle_inputs();
		if (cmd == "R") begin
			assert (cfg_rdata == f1)
				else report_mismatch(name, f1, cfg_rdata);
		end
	endtask

	initial begin
		int fd;
		int r;
		logic [8*24-1:0] name;
		logic [7:0] cmd;
		bit done;
		idle_inputs();
		rst = 1'b1;
		cycle = '0;
		done = 1'b0;
		fd = $fopen("verif/icache_tag_testdata.txt", "r");
		assert (fd != 0)
			else stop_with_error("cannot open the data file verif/icache_tag_testdata.txt");
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		while (!done) begin
			r = $fscanf(fd, "%s", name);
			if (r != 1) begin
				done = 1'b1;
			end else if ((name >> 8) == '0 && name[7:0] == "#") begin
				skip_line(fd);
			end else begin
				r = $fscanf(fd, "%s", cmd);
				assert (r == 1)
					else stop_with_error($sformatf("data line for test %0s has no command", name));
				run_command(fd, name, cmd);
			end
		end
		drain_lookups();
		$fclose(fd);
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/icache_tag_defines.svh */
// widths and config register map for the icache tag array, include wherever these sizes are needed
`ifndef ICACHE_TAG_DEFINES_SVH
`define ICACHE_TAG_DEFINES_SVH

// tag array geometry
`define TAG_IDX_W 6
`define TAG_ADDR_W 20
`define TAG_ENTRY_W 22

// secded check bits and the stored word they extend
`define TAG_ECC_W 7
`define TAG_WORD_W 29

// configuration port
`define CFG_ADDR_W 2
`define CFG_CTRL 2'd0
`define CFG_INJECT 2'd1
`define CFG_CORR_CNT 2'd2
`define CFG_UNCORR_CNT 2'd3

`endif

/* verilog/icache_tag_ecc_ram.sv */
// icache tag array wrapper that maps the packed tag port onto the generic ram model
`timescale 1ns/10ps
`default_nettype none
`include "icache_tag_defines.svh"

module icache_tag_ecc_ram (
	input logic clk,
	input logic icache_tag_cs,
	input logic [`TAG_IDX_W-1:0] icache_tag_addr,
	input icache_tag_pkg::tag_word_t icache_tag_wdata,
	input logic icache_tag_we,
	output icache_tag_pkg::tag_word_t icache_tag_rdata
);

	import icache_tag_pkg::*;

	logic [`TAG_WORD_W-1:0] ram_rdata;

	tag_ram_model #(
		.ADDR_W(`TAG_IDX_W),
		.DATA_W(`TAG_WORD_W)
	) u_ram (
		.clk(clk),
		.cs(icache_tag_cs),
		.we(icache_tag_we),
		.addr(icache_tag_addr),
		.din(icache_tag_wdata),
		.dout(ram_rdata)
	);

	assign icache_tag_rdata = tag_word_t'(ram_rdata); // entry in the upper bits, check bits below

	// a write strobe without a chip select would be silently dropped by the macro
	a_we_needs_cs: assert property (@(posedge clk) !icache_tag_cs |-> !icache_tag_we)
		else $error("tag ram write enable without chip select");

	a_addr_known: assert property (@(posedge clk) icache_tag_cs |-> !$isunknown(icache_tag_addr))
		else $error("tag ram accessed with unknown address");

endmodule

`default_nettype wire

/* verilog/icache_tag_pkg.sv */
// shared structs and the secded helpers of the icache tag array, compile before any module
`default_nettype none
`include "icache_tag_defines.svh"

package icache_tag_pkg;

	localparam int ECC_POS_BASE = 33; // data bit i sits at hamming position i+33

	typedef logic [`TAG_ECC_W-2:0] ecc_ham_t;

	typedef struct packed {
		logic valid;
		logic lock;
		logic [`TAG_ADDR_W-1:0] tag;
	} tag_entry_t;

	typedef struct packed {
		tag_entry_t entry;
		logic [`TAG_ECC_W-1:0] ecc; // msb is overall parity
	} tag_word_t;

	typedef struct packed {
		logic vld;
		logic [`TAG_IDX_W-1:0] index;
		logic [`TAG_ADDR_W-1:0] tag;
	} lookup_req_t;

	typedef struct packed {
		logic vld;
		logic [`TAG_IDX_W-1:0] index;
		logic [`TAG_ADDR_W-1:0] tag;
		logic lock;
	} fill_req_t;

	typedef struct packed {
		logic vld;
		logic hit;
		logic lock;
		logic corrected;
		logic uncorrectable;
	} lookup_rsp_t;

	typedef struct packed {
		logic vld;
		logic we;
		logic [`CFG_ADDR_W-1:0] addr;
		logic [31:0] wdata;
	} cfg_req_t;

	typedef struct packed {
		logic corrected;
		logic uncorrectable;
	} ecc_event_t;

	function automatic logic [`TAG_ECC_W-1:0] secded_encode(input tag_entry_t e);
		logic [`TAG_ENTRY_W-1:0] d;
		ecc_ham_t h;
		d = e;
		h = '0;
		for (int i = 0; i < `TAG_ENTRY_W; i++) begin
			if (d[i])
				h = h ^ ecc_ham_t'(i + ECC_POS_BASE);
		end
		return {^{d, h}, h}; // parity bit makes the whole word even
	endfunction

	function automatic logic [`TAG_ECC_W-1:0] secded_syndrome(input tag_word_t w);
		logic [`TAG_ECC_W-1:0] chk;
		chk = secded_encode(w.entry);
		return {^w, chk[`TAG_ECC_W-2:0] ^ w.ecc[`TAG_ECC_W-2:0]}; // msb set when parity is odd
	endfunction

endpackage

`default_nettype wire

/* verilog/icache_tag_top.sv */
// top of the icache tag array with ecc, joins config registers, lookup pipeline and tag ram
`timescale 1ns/10ps
`default_nettype none
`include "icache_tag_defines.svh"

module icache_tag_top (
	input logic clk,
	input logic rst,
	input icache_tag_pkg::lookup_req_t lookup_req,
	input icache_tag_pkg::fill_req_t fill_req,
	output icache_tag_pkg::lookup_rsp_t lookup_rsp,
	input icache_tag_pkg::cfg_req_t cfg_req,
	output logic [31:0] cfg_rdata
);

	import icache_tag_pkg::*;

	logic ecc_en;
	logic [`TAG_WORD_W-1:0] inject_mask;
	logic inject_used;
	ecc_event_t err_evt;
	logic ram_cs;
	logic ram_we;
	logic [`TAG_IDX_W-1:0] ram_addr;
	tag_word_t ram_wdata;
	tag_word_t ram_rdata;

	tag_cfg_regs u_cfg (
		.clk(clk),
		.rst(rst),
		.cfg_req(cfg_req),
		.cfg_rdata(cfg_rdata),
		.ecc_en(ecc_en),
		.inject_mask(inject_mask),
		.inject_used(inject_used),
		.err_evt(err_evt)
	);

	tag_lookup u_lookup (
		.clk(clk),
		.rst(rst),
		.lookup_req(lookup_req),
		.fill_req(fill_req),
		.ecc_en(ecc_en),
		.inject_mask(inject_mask),
		.inject_used(inject_used),
		.ram_cs(ram_cs),
		.ram_we(ram_we),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata),
		.lookup_rsp(lookup_rsp),
		.err_evt(err_evt)
	);

	icache_tag_ecc_ram u_tag_ram (
		.clk(clk),
		.icache_tag_cs(ram_cs),
		.icache_tag_addr(ram_addr),
		.icache_tag_wdata(ram_wdata),
		.icache_tag_we(ram_we),
		.icache_tag_rdata(ram_rdata)
	);

endmodule

`default_nettype wire

/* verilog/tag_cfg_regs.sv */
// configuration and status registers for the icache tag ecc, written and read over the cfg port
`timescale 1ns/10ps
`default_nettype none
`include "icache_tag_defines.svh"

module tag_cfg_regs (
	input logic clk,
	input logic rst,
	input icache_tag_pkg::cfg_req_t cfg_req,
	output logic [31:0] cfg_rdata,
	output logic ecc_en,
	output logic [`TAG_WORD_W-1:0] inject_mask,
	input logic inject_used,
	input icache_tag_pkg::ecc_event_t err_evt
);

	import icache_tag_pkg::*;

	localparam int CNT_W = 16;

	logic [CNT_W-1:0] corr_cnt;
	logic [CNT_W-1:0] uncorr_cnt;
	logic wr;
	logic rd;
	logic [31:0] rd_mux;

	assign wr = cfg_req.vld && cfg_req.we;
	assign rd = cfg_req.vld && !cfg_req.we;

	always_comb begin
		case (cfg_req.addr)
			`CFG_CTRL: rd_mux = {31'b0, ecc_en};
			`CFG_INJECT: rd_mux = {{(32 - `TAG_WORD_W){1'b0}}, inject_mask};
			`CFG_CORR_CNT: rd_mux = {{(32 - CNT_W){1'b0}}, corr_cnt};
			default: rd_mux = {{(32 - CNT_W){1'b0}}, uncorr_cnt};
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ecc_en <= 1'b1;
			inject_mask <= '0;
			corr_cnt <= '0;
			uncorr_cnt <= '0;
			cfg_rdata <= '0;
		end else begin
			if (rd)
				cfg_rdata <= rd_mux; // held until the next read
			if (inject_used)
				inject_mask <= '0;
			if (err_evt.corrected && (corr_cnt != '1))
				corr_cnt <= corr_cnt + 1'b1;
			if (err_evt.uncorrectable && (uncorr_cnt != '1))
				uncorr_cnt <= uncorr_cnt + 1'b1;
			if (wr) begin
				case (cfg_req.addr)
					`CFG_CTRL: ecc_en <= cfg_req.wdata[0];
					`CFG_INJECT: inject_mask <= cfg_req.wdata[`TAG_WORD_W-1:0];
					`CFG_CORR_CNT: corr_cnt <= '0; // any write data clears
					default: uncorr_cnt <= '0;
				endcase
			end
		end
	end

	a_inject_armed: assert property (@(posedge clk) disable iff (rst)
		inject_used |-> (inject_mask != '0))
		else $error("inject mask consumed while empty");

endmodule

`default_nettype wire

/* verilog/tag_ecc_check.sv */
// combinational secded decoder for a stored tag word, used in the second lookup stage
`timescale 1ns/10ps
`default_nettype none
`include "icache_tag_defines.svh"

module tag_ecc_check (
	input icache_tag_pkg::tag_word_t word,
	input logic ecc_en,
	output icache_tag_pkg::tag_entry_t entry,
	output logic corrected,
	output logic uncorrectable
);

	import icache_tag_pkg::*;

	logic [`TAG_ECC_W-1:0] syn;
	ecc_ham_t syn_ham;
	logic syn_par;
	logic [`TAG_ENTRY_W-1:0] raw;
	logic [`TAG_ENTRY_W-1:0] flip;
	logic known_pos;
	logic single_err;
	logic double_err;

	assign syn = secded_syndrome(word);
	assign {syn_par, syn_ham} = syn;
	assign raw = word.entry;

	// one data bit matches the syndrome at most
	always_comb begin
		flip = '0;
		for (int i = 0; i < `TAG_ENTRY_W; i++) begin
			if (syn_ham == ecc_ham_t'(i + ECC_POS_BASE))
				flip[i] = 1'b1;
		end
	end

	// zero or one-hot syndrome means the flip sat in a check bit
	assign known_pos = (|flip) || $onehot0(syn_ham);

	assign single_err = syn_par && known_pos;
	assign double_err = (!syn_par && (syn_ham != '0)) || (syn_par && !known_pos);

	assign entry = (ecc_en && single_err) ? tag_entry_t'(raw ^ flip) : word.entry;
	assign corrected = ecc_en && single_err;
	assign uncorrectable = ecc_en && double_err; // flags stay quiet with ecc off

endmodule

`default_nettype wire

/* verilog/tag_lookup.sv */
// fill encoder and two-stage lookup pipeline of the icache tag array, sits between requests and ram
`timescale 1ns/10ps
`default_nettype none
`include "icache_tag_defines.svh"

module tag_lookup (
	input logic clk,
	input logic rst,
	input icache_tag_pkg::lookup_req_t lookup_req,
	input icache_tag_pkg::fill_req_t fill_req,
	input logic ecc_en,
	input logic [`TAG_WORD_W-1:0] inject_mask,
	output logic inject_used,
	output logic ram_cs,
	output logic ram_we,
	output logic [`TAG_IDX_W-1:0] ram_addr,
	output icache_tag_pkg::tag_word_t ram_wdata,
	input icache_tag_pkg::tag_word_t ram_rdata,
	output icache_tag_pkg::lookup_rsp_t lookup_rsp,
	output icache_tag_pkg::ecc_event_t err_evt
);

	import icache_tag_pkg::*;

	tag_entry_t fill_entry;
	tag_word_t fill_word;
	logic s1_vld;
	logic [`TAG_ADDR_W-1:0] s1_tag;
	tag_entry_t chk_entry;
	logic chk_corr;
	logic chk_uncorr;
	lookup_rsp_t rsp_nxt;
	ecc_event_t evt_nxt;

	// a fill word lands in the ram at the end of the strobe cycle
	assign fill_entry.valid = 1'b1;
	assign fill_entry.lock = fill_req.lock;
	assign fill_entry.tag = fill_req.tag;
	assign fill_word = {fill_entry, secded_encode(fill_entry)};

	assign ram_cs = fill_req.vld || lookup_req.vld;
	assign ram_we = fill_req.vld;
	assign ram_addr = fill_req.vld ? fill_req.index : lookup_req.index;
	assign ram_wdata = fill_word ^ inject_mask; // one-shot corruption for error tests
	assign inject_used = fill_req.vld && (|inject_mask);

	// stage 1 runs alongside the ram read
	always_ff @(posedge clk) begin
		if (rst) begin
			s1_vld <= 1'b0;
		end else begin
			s1_vld <= lookup_req.vld;
		end
	end

	always_ff @(posedge clk) begin
		s1_tag <= lookup_req.tag;
	end

	// stage 2 decodes the read word
	tag_ecc_check u_check (
		.word(ram_rdata),
		.ecc_en(ecc_en),
		.entry(chk_entry),
		.corrected(chk_corr),
		.uncorrectable(chk_uncorr)
	);

	always_comb begin
		rsp_nxt.vld = s1_vld;
		rsp_nxt.hit = s1_vld && chk_entry.valid && (chk_entry.tag == s1_tag) && !chk_uncorr;
		rsp_nxt.lock = s1_vld && chk_entry.lock;
		rsp_nxt.corrected = s1_vld && chk_corr;
		rsp_nxt.uncorrectable = s1_vld && chk_uncorr;
		evt_nxt.corrected = rsp_nxt.corrected;
		evt_nxt.uncorrectable = rsp_nxt.uncorrectable;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			lookup_rsp <= '0;
			err_evt <= '0;
		end else begin
			lookup_rsp <= rsp_nxt;
			err_evt <= evt_nxt; // lines up with the response strobe
		end
	end

	// the single ram port cannot serve both in one cycle
	a_no_fill_lookup_clash: assert property (@(posedge clk) disable iff (rst)
		!(fill_req.vld && lookup_req.vld))
		else $error("fill and lookup strobed in the same cycle");

endmodule

`default_nettype wire

/* verilog/tag_ram_model.sv */
// behavioral single-port ram with registered read data, instantiated by the tag array wrapper
`timescale 1ns/10ps
`default_nettype none

module tag_ram_model #(
	parameter int ADDR_W = 6,
	parameter int DATA_W = 29
) (
	input logic clk,
	input logic cs,
	input logic we,
	input logic [ADDR_W-1:0] addr,
	input logic [DATA_W-1:0] din,
	output logic [DATA_W-1:0] dout
);

	localparam int DEPTH = 1 << ADDR_W;

	logic [DATA_W-1:0] mem [0:DEPTH-1];

	always_ff @(posedge clk) begin
		if (cs) begin
			if (we) begin
				mem[addr] <= din; // dout keeps the previous read
			end else begin
				dout <= mem[addr];
			end
		end
	end

endmodule

`default_nettype wire
